/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for ALU ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam logic [31:0] NOP_INSN = 32'h0000_0013;  // addi x0, x0, 0

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    // Branch offset is scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
        rv_b_fmt_t b;
    } rv_insn_u;

endpackage

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_BEQ,
        ALU_BNE
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     insn;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [31:0]           insn;
        alu_op_e               alu_op;
        logic                  use_imm;  // Operand b from imm
        logic [XLEN-1:0]       imm;      // Also the branch offset
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
    } id_ex_t;

    // EX/WB contents and retire record
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [31:0]           insn;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic [XLEN-1:0]       wdata;
    } retire_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* fetch_stage.sv */
`default_nettype none

module fetch_stage (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire core_pkg::redirect_t       redirect,
    input  wire logic [core_pkg::XLEN-1:0] imem_rdata,
    output logic [core_pkg::XLEN-1:0]      imem_addr,
    output core_pkg::if_id_t               if_id
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    logic [XLEN-1:0] pc;

    assign imem_addr = pc;  // Word comes back same cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= RESET_PC;
            if_id.valid <= 1'b0;
        end else begin
            pc          <= redirect.taken ? redirect.target : pc + XLEN'(4);
            if_id.valid <= !redirect.taken;  // Squash wrong-path word
        end
        if_id.pc   <= pc;
        if_id.insn <= (rst || redirect.taken) ? NOP_INSN : imem_rdata;
    end

    // Branch targets must stay on word boundaries
    a_pc_aligned : assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire core_pkg::if_id_t  if_id,
    input  wire logic              flush,
    input  wire core_pkg::retire_t wb,
    output core_pkg::id_ex_t       id_ex
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    rv_insn_u        insn;
    id_ex_t          id_ex_d;
    logic            writes;  // Instruction produces an rd value
    logic [XLEN-1:0] rf [32];

    assign insn = if_id.insn;

    // Read with bypass of the write happening this cycle
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_ADDR_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb.valid && wb.rd_we && wb.rd == idx) begin
            return wb.wdata;
        end
        return rf[idx];
    endfunction

    always_comb begin
        writes          = 1'b0;
        id_ex_d.valid   = if_id.valid && !flush;
        id_ex_d.pc      = if_id.pc;
        id_ex_d.insn    = if_id.insn;
        id_ex_d.alu_op  = ALU_ADD;
        id_ex_d.use_imm = 1'b0;
        id_ex_d.imm     = {{(XLEN-12){insn.i.imm[11]}}, insn.i.imm};
        id_ex_d.rs1     = insn.r.rs1;
        id_ex_d.rs2     = insn.r.rs2;
        id_ex_d.rd      = insn.r.rd;

        case (insn.r.opcode)
            OPC_OP: begin
                // Only funct7 zero, or SUB
                writes = (insn.r.funct7 == '0)
                      || (insn.r.funct7 == F7_SUB && insn.r.funct3 == F3_ADD_SUB);
                case (insn.r.funct3)
                    F3_ADD_SUB: id_ex_d.alu_op = (insn.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     id_ex_d.alu_op = ALU_SLT;
                    F3_XOR:     id_ex_d.alu_op = ALU_XOR;
                    F3_OR:      id_ex_d.alu_op = ALU_OR;
                    F3_AND:     id_ex_d.alu_op = ALU_AND;
                    default:    writes = 1'b0;  // Shifts, SLTU
                endcase
            end
            OPC_OP_IMM: begin
                id_ex_d.use_imm = 1'b1;
                writes          = 1'b1;
                case (insn.r.funct3)
                    F3_ADD_SUB: id_ex_d.alu_op = ALU_ADD;
                    F3_SLT:     id_ex_d.alu_op = ALU_SLT;
                    F3_XOR:     id_ex_d.alu_op = ALU_XOR;
                    F3_OR:      id_ex_d.alu_op = ALU_OR;
                    F3_AND:     id_ex_d.alu_op = ALU_AND;
                    default:    writes = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                id_ex_d.imm = {{(XLEN-12){insn.b.imm12}}, insn.b.imm11,
                               insn.b.imm10_5, insn.b.imm4_1, 1'b0};
                case (insn.r.funct3)
                    F3_BEQ:  id_ex_d.alu_op = ALU_BEQ;
                    F3_BNE:  id_ex_d.alu_op = ALU_BNE;
                    default: id_ex_d.alu_op = ALU_ADD;  // Other compares retire as NOP
                endcase
            end
            default: ;  // Non-writing ADD
        endcase

        // x0 result is computed but never stored
        id_ex_d.rd_we   = writes && (insn.r.rd != '0);
        id_ex_d.rs1_val = rf_read(insn.r.rs1);
        id_ex_d.rs2_val = rf_read(insn.r.rs2);
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd_we) begin
            rf[wb.rd] <= wb.wdata;
        end
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_d;
        if (rst) begin
            id_ex.valid <= 1'b0;
        end
    end

    // Write records coming back from execute never target x0
    a_no_x0_write : assert property (@(posedge clk) disable iff (rst)
        wb.valid && wb.rd_we |-> wb.rd != '0);

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire core_pkg::id_ex_t id_ex,
    output core_pkg::redirect_t   redirect,
    output core_pkg::retire_t     wb
);
    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] result;
    logic            eq;
    retire_t         wb_d;

    // Take the previous result when it targets this source
    function automatic logic [XLEN-1:0] fwd_operand(input logic [REG_ADDR_W-1:0] idx,
                                                    input logic [XLEN-1:0]       val);
        if (wb.valid && wb.rd_we && wb.rd != '0 && wb.rd == idx) begin
            return wb.wdata;
        end
        return val;
    endfunction

    always_comb begin
        op_a    = fwd_operand(id_ex.rs1, id_ex.rs1_val);
        rs2_fwd = fwd_operand(id_ex.rs2, id_ex.rs2_val);
        op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;
        eq      = (op_a == op_b);

        case (id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = '0;  // Branches write nothing
        endcase
    end

    // Resolved here, fetch follows next cycle
    assign redirect.taken = id_ex.valid
                         && ((id_ex.alu_op == ALU_BEQ && eq)
                          || (id_ex.alu_op == ALU_BNE && !eq));
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_comb begin
        wb_d.valid = id_ex.valid;
        wb_d.pc    = id_ex.pc;
        wb_d.insn  = id_ex.insn;
        wb_d.rd    = id_ex.rd;
        wb_d.rd_we = id_ex.rd_we;
        wb_d.wdata = result;
    end

    always_ff @(posedge clk) begin
        wb <= wb_d;
        if (rst) begin
            wb.valid <= 1'b0;
        end
    end

    // Taken branch leaves ID/EX empty for the two younger slots
    a_flush_on_taken : assert property (@(posedge clk) disable iff (rst)
        redirect.taken |=> !id_ex.valid ##1 !id_ex.valid);

endmodule

`default_nettype wire

/* rv_core.sv */
`default_nettype none

module rv_core (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [core_pkg::XLEN-1:0] imem_rdata,
    output logic [core_pkg::XLEN-1:0]      imem_addr,
    output core_pkg::retire_t              retire
);
    import core_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    redirect_t redirect;

    fetch_stage i_fetch_stage (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .if_id      (if_id)
    );

    decode_stage i_decode_stage (
        .clk   (clk),
        .rst   (rst),
        .if_id (if_id),
        .flush (redirect.taken),
        .wb    (retire),  // EX/WB record feeds the register file
        .id_ex (id_ex)
    );

    execute_stage i_execute_stage (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .redirect (redirect),
        .wb       (retire)
    );

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;
    import rv_isa_pkg::*;

    localparam int MAX_WORDS      = 64;
    localparam int MAX_RECORDS    = 64;
    localparam int RETIRE_LATENCY = 3;  // Fetch to retire, in cycles
    localparam int BRANCH_BUBBLES = 2;  // Idle retire cycles after a taken branch

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic [XLEN-1:0]       wdata;
    } expect_t;

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_rdata;
    retire_t         retire;

    logic [31:0] prog [MAX_WORDS];
    expect_t     expected [MAX_RECORDS];
    int          prog_len;
    int          exp_count;
    int          errors;
    bit          loaded;

    rv_core i_rv_core (
        .clk        (clk),
        .rst        (rst),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .retire     (retire)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Program words from address 0, NOP everywhere else
    function automatic logic [31:0] imem_word(input logic [XLEN-1:0] addr);
        if ((addr >> 2) < XLEN'(prog_len)) begin
            return prog[addr >> 2];
        end
        return NOP_INSN;
    endfunction

    assign imem_rdata = imem_word(imem_addr);  // Same-cycle answer

    // Idle cycles before a retire, counted from reset release or the previous retire
    function automatic int expected_gap(input int idx);
        if (idx == 0) begin
            return RETIRE_LATENCY;
        end
        if (expected[idx].pc != expected[idx-1].pc + 32'd4) begin
            return BRANCH_BUBBLES;  // Two younger slots squashed
        end
        return 0;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] actual,
                                 input logic [31:0] expect_val);
        if (actual !== expect_val) begin
            errors++;
            $display("Error at time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expect_val);
        end
    endtask

    task automatic load_stimulus;
        int               fd;
        int               fields;
        int               rd_val;
        int               we_val;
        logic [8*96-1:0]  line;
        logic [8*4-1:0]   tag;
        logic [31:0]      word;
        logic [31:0]      pc_val;
        logic [31:0]      wdata_val;
        fd = $fopen("rv_core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file rv_core_stimulus.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            tag = '0;
            fields = $sscanf(line, "%s", tag);
            if (tag == "P") begin
                fields = $sscanf(line, "%s %h", tag, word);
                if (fields == 2 && prog_len < MAX_WORDS) begin
                    prog[prog_len] = word;
                    prog_len++;
                end else begin
                    $display("A program line in the stimulus file could not be used");
                    errors++;
                end
            end else if (tag == "E") begin
                fields = $sscanf(line, "%s %h %d %d %h", tag, pc_val, rd_val, we_val,
                                 wdata_val);
                if (fields == 5 && exp_count < MAX_RECORDS) begin
                    expected[exp_count].pc    = pc_val;
                    expected[exp_count].rd    = rd_val[4:0];
                    expected[exp_count].rd_we = we_val[0];
                    expected[exp_count].wdata = wdata_val;
                    exp_count++;
                end else begin
                    $display("An expected-record line in the stimulus file could not be used");
                    errors++;
                end
            end
        end
        $fclose(fd);
        if (exp_count == 0) begin
            $display("The stimulus file holds no expected retire records");
            errors++;
        end
    endtask

    // One retire record against the next expected one
    task automatic match_retire(input int idx);
        string tag;
        tag = $sformatf("retire %0d", idx);
        compare_field({tag, " pc"}, retire.pc, expected[idx].pc);
        compare_field({tag, " insn"}, retire.insn, imem_word(expected[idx].pc));
        compare_field({tag, " rd"}, retire.rd, expected[idx].rd);
        compare_field({tag, " rd_we"}, retire.rd_we, expected[idx].rd_we);
        compare_field({tag, " wdata"}, retire.wdata, expected[idx].wdata);
    endtask

    initial begin
        int idle_cycles;
        int rec_idx;
        errors      = 0;
        prog_len    = 0;
        exp_count   = 0;
        idle_cycles = 0;
        rec_idx     = 0;
        rst         = 1'b1;
        load_stimulus();
        loaded = 1'b1;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Sample on the falling edge, away from the DUT's updates
        while (rec_idx < exp_count) begin
            @(negedge clk);
            if (retire.valid) begin
                compare_field($sformatf("idle cycles before retire %0d", rec_idx),
                              idle_cycles, expected_gap(rec_idx));
                match_retire(rec_idx);
                rec_idx++;
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
        end

        $display("Checked %0d retire records, errors: %0d", rec_idx, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from program and record counts
    initial begin
        wait (loaded);
        #((prog_len + exp_count + 20) * 10);
        $display("Retirement stalled, the expected retire records did not all arrive");
        $display("Checked records incomplete, errors: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core_stimulus.txt */
# P <instruction word hex>, in order from address 0
# E <pc hex> <rd dec> <rd_we> <wdata hex>, in retire order
P 00500093 # 00 addi x1, x0, 5
P FFF00113 # 04 addi x2, x0, -1
P 002081B3 # 08 add  x3, x1, x2
P 40308233 # 0C sub  x4, x1, x3
P 001172B3 # 10 and  x5, x2, x1
P 00326333 # 14 or   x6, x4, x3
P 0020C3B3 # 18 xor  x7, x1, x2
P 0013A433 # 1C slt  x8, x7, x1
P 0070A4B3 # 20 slt  x9, x1, x7
P FF00C513 # 24 xori x10, x1, -16
P 7F017593 # 28 andi x11, x2, 0x7f0
P 80006613 # 2C ori  x12, x0, -2048
P FFB3A693 # 30 slti x13, x7, -5
P 00708013 # 34 addi x0, x1, 7
P 00100733 # 38 add  x14, x0, x1
P 00108663 # 3C beq  x1, x1, +12
P 00100793 # 40 addi x15, x0, 1
P 00200793 # 44 addi x15, x0, 2
P 00308813 # 48 addi x16, x1, 3
P 00181663 # 4C bne  x16, x1, +12
P 00300793 # 50 addi x15, x0, 3
P 00400793 # 54 addi x15, x0, 4
P 00109463 # 58 bne  x1, x1, +8
P FF880893 # 5C addi x17, x16, -8
P 01088933 # 60 add  x18, x17, x16
E 00 1 1 00000005
E 04 2 1 FFFFFFFF
E 08 3 1 00000004
E 0C 4 1 00000001
E 10 5 1 00000005
E 14 6 1 00000005
E 18 7 1 FFFFFFFA
E 1C 8 1 00000001
E 20 9 1 00000000
E 24 10 1 FFFFFFF5
E 28 11 1 000007F0
E 2C 12 1 FFFFF800
E 30 13 1 00000001
E 34 0 0 0000000C
E 38 14 1 00000005
E 3C 12 0 00000000
E 48 16 1 00000008
E 4C 12 0 00000000
E 58 8 0 00000000
E 5C 17 1 00000000
E 60 18 1 00000008

/* files.f */
rv_isa_pkg.sv
core_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
rv_core.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rv_isa_pkg.sv
  - core_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv
